// ==== flist.f ====
+incdir+rtl
rtl/fpAluPkg.sv
rtl/fpResultIf.sv
rtl/fpOperandRegs.sv
rtl/fpNormalizer.sv
rtl/fpAddSub.sv
rtl/fpMultiplier.sv
rtl/fpResultSelect.sv
rtl/fpAluTop.sv
tests/fpClockGen.sv
tests/fpAluTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the fpAluTop testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module fpAluTb -o simFpAlu

./obj_dir/simFpAlu | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== tests/fpAluTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpAluTb;

	// One stimulus row with its expected result and flags
	typedef struct packed
	{
		fpAluPkg::fpWord a;
		fpAluPkg::fpWord b;
		logic [1:0]      op;
		fpAluPkg::fpWord want;
		logic            wantOverflow;
		logic            wantUnderflow;
		logic            wantException;
		logic [3:0]      idleBefore;
	} vecRow;

	localparam int numRows = 14;
	// Reset, one cycle per row, and room for idle cycles and the pipeline drain
	localparam int cycleLimit = 16 + numRows + 20;

	logic clk;
	logic reset;
	logic start;
	fpAluPkg::fpWord opA;
	fpAluPkg::fpWord opB;
	fpAluPkg::fpOp op;
	fpAluPkg::fpWord result;
	logic overflow;
	logic underflow;
	logic exception;
	logic resultValid;

	vecRow vectors [numRows];
	int unsigned pendRow [$];
	int unsigned pendDue [$];
	int unsigned cycleCount = 0;
	int unsigned errorCount = 0;
	int unsigned checkedCount = 0;

	fpClockGen clockGen
	(
		.clk   (clk),
		.reset (reset)
	);

	fpAluTop dut
	(
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.opA         (opA),
		.opB         (opB),
		.op          (op),
		.result      (result),
		.overflow    (overflow),
		.underflow   (underflow),
		.exception   (exception),
		.resultValid (resultValid)
	);

	//////////////////////////////
	// Vectors
	//////////////////////////////

	task automatic loadVectors();
		// a, b, op, result, overflow, underflow, exception, idle cycles before
		vectors[0]  = '{32'h3F800000, 32'h40000000, 2'd0, 32'h40400000, 1'b0, 1'b0, 1'b0, 4'd2};
		vectors[1]  = '{32'h3F800000, 32'h40000000, 2'd1, 32'hBF800000, 1'b0, 1'b0, 1'b0, 4'd0};
		vectors[2]  = '{32'h40200000, 32'hBFC00000, 2'd1, 32'h40800000, 1'b0, 1'b0, 1'b0, 4'd0};
		vectors[3]  = '{32'hBF400000, 32'h3E800000, 2'd0, 32'hBF000000, 1'b0, 1'b0, 1'b0, 4'd0};
		// Products, code 3 runs through the multiplier as well
		vectors[4]  = '{32'h3FC00000, 32'h40000000, 2'd2, 32'h40400000, 1'b0, 1'b0, 1'b0, 4'd1};
		vectors[5]  = '{32'hC0400000, 32'h3F000000, 2'd2, 32'hBFC00000, 1'b0, 1'b0, 1'b0, 4'd0};
		vectors[6]  = '{32'h3F800000, 32'h3F800000, 2'd2, 32'h3F800000, 1'b0, 1'b0, 1'b0, 4'd0};
		vectors[7]  = '{32'h3FC00000, 32'h40000000, 2'd3, 32'h40400000, 1'b0, 1'b0, 1'b0, 4'd0};
		// NaN or infinity operands give all ones
		vectors[8]  = '{32'h7FC00000, 32'h3F800000, 2'd0, 32'hFFFFFFFF, 1'b0, 1'b0, 1'b1, 4'd2};
		vectors[9]  = '{32'h3F800000, 32'h7F800000, 2'd1, 32'hFFFFFFFF, 1'b0, 1'b0, 1'b1, 4'd0};
		vectors[10] = '{32'h7F800000, 32'h3F800000, 2'd2, 32'hFFFFFFFF, 1'b0, 1'b0, 1'b1, 4'd0};
		// 2^100 squared overflows, 2^-100 squared underflows
		vectors[11] = '{32'h71800000, 32'h71800000, 2'd2, 32'h7F800000, 1'b1, 1'b0, 1'b0, 4'd0};
		vectors[12] = '{32'hF1800000, 32'h71800000, 2'd2, 32'hFF800000, 1'b1, 1'b0, 1'b0, 4'd0};
		vectors[13] = '{32'h0D800000, 32'h0D800000, 2'd2, 32'h00000000, 1'b0, 1'b1, 1'b0, 4'd0};
	endtask

	task automatic compareValue(string name, int unsigned row, logic [31:0] got,
		logic [31:0] want);
		assert (got === want)
		else
		begin
			errorCount++;
			$display("[FAIL] row %0d %s: got 0x%08h, expected 0x%08h", row, name, got, want);
		end
	endtask

	//////////////////////////////
	// Cycle counter and timeout
	//////////////////////////////

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles with %0d results pending", cycleCount,
				pendRow.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Checker
	//////////////////////////////

	// Outputs are sampled on the falling edge, half a period after they change
	always @(negedge clk)
	begin
		int unsigned row;
		int unsigned due;
		if (reset)
		begin
			if (cycleCount > 0)
			begin
				assert (resultValid === 1'b0)
				else
				begin
					errorCount++;
					$display("resultValid was high during reset at cycle %0d", cycleCount);
				end
			end
		end
		else if (resultValid === 1'b1)
		begin
			assert (pendRow.size() != 0)
			else
			begin
				errorCount++;
				$display("resultValid was high at cycle %0d with no operation pending",
					cycleCount);
			end
			if (pendRow.size() != 0)
			begin
				row = pendRow.pop_front();
				due = pendDue.pop_front();
				checkedCount++;
				assert (due == cycleCount)
				else
				begin
					errorCount++;
					$display("Result of row %0d came at cycle %0d instead of cycle %0d",
						row, cycleCount, due);
				end
				compareValue("result", row, result, vectors[row].want);
				compareValue("overflow", row, {31'b0, overflow}, {31'b0, vectors[row].wantOverflow});
				compareValue("underflow", row, {31'b0, underflow},
					{31'b0, vectors[row].wantUnderflow});
				compareValue("exception", row, {31'b0, exception},
					{31'b0, vectors[row].wantException});
			end
		end
		else if (pendDue.size() != 0)
		begin
			// A row whose cycle has passed without resultValid is dropped here
			assert (pendDue[0] > cycleCount)
			else
			begin
				errorCount++;
				$display("No resultValid for row %0d at cycle %0d", pendRow[0], cycleCount);
				void'(pendRow.pop_front());
				void'(pendDue.pop_front());
			end
		end
	end

	//////////////////////////////
	// Driver
	//////////////////////////////

	initial
	begin
		start = 1'b0;
		opA = '0;
		opB = '0;
		op = fpAluPkg::fpOpAdd;
		loadVectors();

		@(negedge reset);
		for (int i = 0; i < numRows; i++)
		begin
			repeat (vectors[i].idleBefore)
			begin
				start = 1'b0;
				@(posedge clk);
				#1;
			end
			start = 1'b1;
			opA = vectors[i].a;
			opB = vectors[i].b;
			op = fpAluPkg::fpOp'(vectors[i].op);
			// Sampled at the next edge, result registered one edge later
			pendRow.push_back(i);
			pendDue.push_back(cycleCount + 2);
			@(posedge clk);
			#1;
		end
		start = 1'b0;

		while (pendRow.size() != 0)
			@(posedge clk);
		// A few quiet cycles to catch a stray resultValid
		repeat (3) @(posedge clk);

		$display("Checked %0d of %0d results, %0d errors", checkedCount, numRows, errorCount);
		if (errorCount == 0 && checkedCount == numRows)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/fpClockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

// Free-running clock for the testbench, with reset held over the first edges
module fpClockGen
(
	output logic clk,
	output logic reset
);

	localparam int halfPeriod = 10;
	localparam int resetCycles = 16;

	initial clk = 1'b0;

	always #halfPeriod clk = ~clk;

	// Reset drops shortly after the last reset edge, like every other DUT input
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== rtl/fpAluTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpAluTop
(
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  fpAluPkg::fpWord opA,
	input  fpAluPkg::fpWord opB,
	input  fpAluPkg::fpOp   op,
	output fpAluPkg::fpWord result,
	output logic            overflow,
	output logic            underflow,
	output logic            exception,
	output logic            resultValid
);

	fpAluPkg::fpWord regOpA;
	fpAluPkg::fpWord regOpB;
	fpAluPkg::fpOp regOp;
	logic issued;

	fpResultIf addSubRes();
	fpResultIf mulRes();

	fpOperandRegs operandRegs
	(
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.opAIn  (opA),
		.opBIn  (opB),
		.opIn   (op),
		.opA    (regOpA),
		.opB    (regOpB),
		.op     (regOp),
		.issued (issued)
	);

	fpAddSub addSub
	(
		.opA (regOpA),
		.opB (regOpB),
		.op  (regOp),
		.res (addSubRes.source)
	);

	fpMultiplier multiplier
	(
		.opA (regOpA),
		.opB (regOpB),
		.res (mulRes.source)
	);

	fpResultSelect resultSelect
	(
		.clk         (clk),
		.reset       (reset),
		.op          (regOp),
		.issued      (issued),
		.addSubRes   (addSubRes.sink),
		.mulRes      (mulRes.sink),
		.result      (result),
		.overflow    (overflow),
		.underflow   (underflow),
		.exception   (exception),
		.resultValid (resultValid)
	);

endmodule

`default_nettype wire

// ==== rtl/fpResultSelect.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpAlu_defs.svh"

module fpResultSelect
(
	input  logic            clk,
	input  logic            reset,
	input  fpAluPkg::fpOp   op,
	input  logic            issued,
	fpResultIf.sink         addSubRes,
	fpResultIf.sink         mulRes,
	output fpAluPkg::fpWord result,
	output logic            overflow,
	output logic            underflow,
	output logic            exception,
	output logic            resultValid
);

	logic useMul;
	fpAluPkg::fpWord pickResult;
	logic pickOverflow;
	logic pickUnderflow;
	logic pickException;
	fpAluPkg::fpWord finalResult;

	// Codes 2 and 3 both go to the multiplier
	assign useMul = (op == fpAluPkg::fpOpMul) || (op == fpAluPkg::fpOpMulAlt);

	assign pickResult = useMul ? mulRes.result : addSubRes.result;
	assign pickOverflow = useMul ? mulRes.overflow : addSubRes.overflow;
	assign pickUnderflow = useMul ? mulRes.underflow : addSubRes.underflow;
	assign pickException = useMul ? mulRes.exception : addSubRes.exception;

	// Overflow gives a signed infinity, underflow a signed zero,
	// an exception alone gives all ones
	always_comb
	begin
		if (pickOverflow)
			finalResult = {pickResult[`FP_WIDTH-1], fpAluPkg::fpExp'(`FP_EXP_MAX), fpAluPkg::fpMan'(0)};
		else if (pickUnderflow)
			finalResult = {pickResult[`FP_WIDTH-1], {(`FP_WIDTH-1){1'b0}}};
		else if (pickException)
			finalResult = '1;
		else
			finalResult = pickResult;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			overflow <= 1'b0;
			underflow <= 1'b0;
			exception <= 1'b0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= issued;
			if (issued)
			begin
				result <= finalResult;
				overflow <= pickOverflow;
				underflow <= pickUnderflow;
				exception <= pickException;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fpMultiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpAlu_defs.svh"

module fpMultiplier
(
	input  fpAluPkg::fpWord opA,
	input  fpAluPkg::fpWord opB,
	fpResultIf.source       res
);

	localparam int topBit = 2*`FP_MAN_WIDTH + 1;
	localparam logic [`FP_EXP_WIDTH+1:0] expBias = `FP_EXP_BIAS;

	fpAluPkg::fpExp expA;
	fpAluPkg::fpExp expB;
	fpAluPkg::fpSig sigA;
	fpAluPkg::fpSig sigB;
	fpAluPkg::fpProduct product;
	fpAluPkg::fpMan manWindow;
	fpAluPkg::fpMan manRound;
	logic roundUp;
	logic [`FP_EXP_WIDTH+1:0] expFull;

	assign expA = opA[`FP_WIDTH-2 -: `FP_EXP_WIDTH];
	assign expB = opB[`FP_WIDTH-2 -: `FP_EXP_WIDTH];
	assign sigA = {|expA, opA[`FP_MAN_WIDTH-1:0]};
	assign sigB = {|expB, opB[`FP_MAN_WIDTH-1:0]};

	assign product = sigA * sigB;

	// A product of 2.0 or more has its leading one on the top bit,
	// otherwise the leading one sits one place lower
	assign manWindow = product[topBit] ? product[topBit-1 -: `FP_MAN_WIDTH]
		: product[topBit-2 -: `FP_MAN_WIDTH];

	// Round up when any discarded bit is set
	assign roundUp = product[topBit] ? |product[`FP_MAN_WIDTH:0]
		: |product[`FP_MAN_WIDTH-1:0];
	assign manRound = manWindow + {{(`FP_MAN_WIDTH-1){1'b0}}, roundUp};

	//////////////////////////////
	// Exponent and flags
	//////////////////////////////

	// Two spare bits: bit 9 is the sign of the biased sum, bit 8 is past 255
	assign expFull = {2'b00, expA} + {2'b00, expB}
		+ {{(`FP_EXP_WIDTH+1){1'b0}}, product[topBit]} - expBias;

	assign res.result = {opA[`FP_WIDTH-1] ^ opB[`FP_WIDTH-1],
		expFull[`FP_EXP_WIDTH-1:0], manRound};
	assign res.exception = (&expA) | (&expB);
	assign res.underflow = expFull[`FP_EXP_WIDTH+1];
	assign res.overflow = !expFull[`FP_EXP_WIDTH+1] && expFull[`FP_EXP_WIDTH];

endmodule

`default_nettype wire

// ==== rtl/fpAddSub.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpAlu_defs.svh"

module fpAddSub
(
	input  fpAluPkg::fpWord opA,
	input  fpAluPkg::fpWord opB,
	input  fpAluPkg::fpOp   op,
	fpResultIf.source       res
);

	logic signA;
	logic signB;
	fpAluPkg::fpExp expA;
	fpAluPkg::fpExp expB;
	fpAluPkg::fpSig sigA;
	fpAluPkg::fpSig sigB;

	logic aGreater;
	fpAluPkg::fpExp expDiff;
	fpAluPkg::fpExp expBig;
	fpAluPkg::fpSig alignA;
	fpAluPkg::fpSig alignB;

	logic effSub;
	fpAluPkg::fpSig addend;
	fpAluPkg::fpSig sum;
	logic carry;
	logic negative;
	fpAluPkg::fpSig magnitude;
	logic resSign;

	fpAluPkg::fpMan manNorm;
	fpAluPkg::fpShift shift;
	fpAluPkg::fpExp expInc;
	fpAluPkg::fpExp expNew;
	logic [`FP_EXP_WIDTH:0] expFinal;

	assign signA = opA[`FP_WIDTH-1];
	assign signB = opB[`FP_WIDTH-1];
	assign expA = opA[`FP_WIDTH-2 -: `FP_EXP_WIDTH];
	assign expB = opB[`FP_WIDTH-2 -: `FP_EXP_WIDTH];

	// Implied bit is cleared only for an operand with a zero exponent
	assign sigA = {|expA, opA[`FP_MAN_WIDTH-1:0]};
	assign sigB = {|expB, opB[`FP_MAN_WIDTH-1:0]};

	//////////////////////////////
	// Exponent alignment
	//////////////////////////////

	// Equal exponents count as A being the larger one
	assign aGreater = (expA >= expB);
	assign expDiff = aGreater ? expA - expB : expB - expA;
	assign expBig = aGreater ? expA : expB;

	// Bits shifted out here are simply dropped
	assign alignA = aGreater ? sigA : sigA >> expDiff;
	assign alignB = aGreater ? sigB >> expDiff : sigB;

	//////////////////////////////
	// Mantissa add or subtract
	//////////////////////////////

	// Magnitudes are subtracted when the requested operation and the signs disagree
	assign effSub = (op == fpAluPkg::fpOpSub) ^ signA ^ signB;

	assign addend = effSub ? ~alignB : alignB;
	assign {carry, sum} = {1'b0, alignA} + {1'b0, addend} + {{`FP_MAN_WIDTH+1{1'b0}}, effSub};

	// Without a carry a subtraction went negative, so B had the larger magnitude
	assign negative = effSub && !carry;
	assign magnitude = negative ? ~sum + 1'b1 : sum;
	assign resSign = negative ? ~signA : signA;

	fpNormalizer normalizer
	(
		.sum    (magnitude),
		.carry  (carry),
		.effSub (effSub),
		.man    (manNorm),
		.shift  (shift)
	);

	//////////////////////////////
	// Exponent adjust and flags
	//////////////////////////////

	assign expInc = expBig + 1'b1;
	assign expNew = (carry && !effSub) ? expInc : expBig;

	// Bit 8 set means the normalizer shift went below zero
	assign expFinal = {1'b0, expNew} - {{(`FP_EXP_WIDTH+1-`FP_SHIFT_WIDTH){1'b0}}, shift};

	assign res.result = {resSign, expFinal[`FP_EXP_WIDTH-1:0], manNorm};
	assign res.exception = (&expA) | (&expB);
	assign res.underflow = expFinal[`FP_EXP_WIDTH];
	assign res.overflow = (&expInc) && (shift == '0);

endmodule

`default_nettype wire

// ==== rtl/fpNormalizer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fpAlu_defs.svh"

module fpNormalizer
(
	input  fpAluPkg::fpSig   sum,
	input  logic             carry,
	input  logic             effSub,
	output fpAluPkg::fpMan   man,
	output fpAluPkg::fpShift shift
);

	fpAluPkg::fpShift lead;
	fpAluPkg::fpSig shifted;
	logic found;

	// Leading-one search from the implied position downwards
	always_comb
	begin
		lead = '0;
		found = 1'b0;
		for (int i = `FP_MAN_WIDTH; i >= 0; i--)
		begin
			if (!found && sum[i])
			begin
				found = 1'b1;
				lead = fpAluPkg::fpShift'(`FP_MAN_WIDTH - i);
			end
		end
	end

	// An all-zero sum leaves lead at zero, so the mantissa comes out zero
	assign shifted = sum << lead;

	always_comb
	begin
		if (carry && !effSub)
		begin
			// Carry out of an addition: the carry becomes the implied bit,
			// the sum moves right by one and the dropped bit is added back
			man = sum[`FP_MAN_WIDTH:1] + {{(`FP_MAN_WIDTH-1){1'b0}}, sum[0]};
			shift = '0;
		end
		else
		begin
			man = shifted[`FP_MAN_WIDTH-1:0];
			shift = lead;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fpOperandRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module fpOperandRegs
(
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  fpAluPkg::fpWord opAIn,
	input  fpAluPkg::fpWord opBIn,
	input  fpAluPkg::fpOp   opIn,
	output fpAluPkg::fpWord opA,
	output fpAluPkg::fpWord opB,
	output fpAluPkg::fpOp   op,
	output logic            issued
);

	// Operand stage, only loaded when a new operation arrives
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			opA <= opAIn;
			opB <= opBIn;
			op  <= opIn;
		end
	end

	// Issued follows start by one edge and marks fresh operands for the
	// arithmetic units and the result stage
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			issued <= 1'b0;
		end
		else
		begin
			issued <= start;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fpResultIf.sv ====
`timescale 1ns/1ns
`default_nettype none

// Result word and status flags of one arithmetic unit, all combinational
interface fpResultIf;

	fpAluPkg::fpWord result;
	logic overflow;
	logic underflow;
	logic exception;

	modport source
	(
		output result, overflow, underflow, exception
	);

	modport sink
	(
		input result, overflow, underflow, exception
	);

endinterface

`default_nettype wire

// ==== rtl/fpAluPkg.sv ====
`default_nettype none

`include "fpAlu_defs.svh"

package fpAluPkg;

	// Packed floating-point word
	typedef logic [`FP_WIDTH-1:0] fpWord;

	// Field types
	typedef logic [`FP_EXP_WIDTH-1:0] fpExp;
	typedef logic [`FP_MAN_WIDTH-1:0] fpMan;

	// Significand with the implied bit on top
	typedef logic [`FP_MAN_WIDTH:0] fpSig;

	// Product of two significands
	typedef logic [2*`FP_MAN_WIDTH+1:0] fpProduct;

	typedef logic [`FP_SHIFT_WIDTH-1:0] fpShift;

	// Code 3 used to be divide and now runs through the multiplier
	typedef enum logic [1:0]
	{
		fpOpAdd    = 2'd0,
		fpOpSub    = 2'd1,
		fpOpMul    = 2'd2,
		fpOpMulAlt = 2'd3
	} fpOp;

endpackage

`default_nettype wire

// ==== rtl/fpAlu_defs.svh ====
`ifndef FP_ALU_DEFS_SVH
`define FP_ALU_DEFS_SVH

// Single-precision word layout: sign, biased exponent, stored mantissa

// Full word width
`define FP_WIDTH 32

// Biased exponent field
`define FP_EXP_WIDTH 8

// Stored mantissa field, without the implied bit
`define FP_MAN_WIDTH 23

// Exponent bias of the format
`define FP_EXP_BIAS 127

// All-ones exponent marks infinity or NaN
`define FP_EXP_MAX 255

// Enough bits to count a left shift across the whole significand
`define FP_SHIFT_WIDTH 5

`endif
